/* verilog/icache_geom_pkg.sv */
package icache_geom_pkg;

    // Cache geometry
    localparam int NUM_SETS    = 8;
    localparam int BLOCK_WORDS = 4;

    localparam int BYTE_BITS = 2;
    localparam int SET_BITS  = $clog2(NUM_SETS);
    localparam int WORD_BITS = $clog2(BLOCK_WORDS);
    localparam int TAG_BITS  = 32 - SET_BITS - WORD_BITS - BYTE_BITS;

    typedef logic [SET_BITS-1:0]  set_idx_t;
    typedef logic [WORD_BITS-1:0] word_idx_t;
    typedef logic [TAG_BITS-1:0]  tag_t;

    typedef logic [31:0] word_t;

    // Address fields, MSB first
    typedef struct packed {
        tag_t                 tag;
        set_idx_t             set;
        word_idx_t            word;
        logic [BYTE_BITS-1:0] byte_off;
    } fetch_fields_t;

    // Same fetch address, raw or split into fields
    typedef union packed {
        logic [31:0]   raw;
        fetch_fields_t f;
    } fetch_addr_u;

endpackage

/* verilog/icache_port_pkg.sv */
package icache_port_pkg;

    import icache_geom_pkg::*;

    // Core fetch side
    typedef struct packed {
        logic        enable;
        fetch_addr_u addr;
    } fetch_req_t;

    typedef struct packed {
        word_t instruction;
        logic  ready;
        logic  busy;
    } fetch_rsp_t;

    // SDRAM controller side
    typedef struct packed {
        logic        request;
        logic [31:0] addr;
    } mem_req_t;

    typedef struct packed {
        word_t data;
        logic  data_ready;
    } mem_rsp_t;

endpackage

/* verilog/icache_ctrl.sv */
`timescale 1ns/10ps

module icache_ctrl
    import icache_geom_pkg::*;
    import icache_port_pkg::*;
#(
    parameter int NUM_WAYS = 4
) (
    input  logic                        Clk,
    input  logic                        rst_n,
    input  fetch_req_t                  fetch_req,
    input  logic                        hit,
    input  logic [$clog2(NUM_WAYS)-1:0] hit_way,
    input  logic [$clog2(NUM_WAYS)-1:0] victim_way,
    input  word_t                       rd_data,
    input  word_t                       crit_word,
    input  logic                        last_word,
    input  logic                        mem_data_ready,
    output logic                        lookup_en,
    output logic                        rd_en,
    output logic [$clog2(NUM_WAYS)-1:0] rd_way,
    output logic                        fill_en,
    output logic [$clog2(NUM_WAYS)-1:0] fill_way,
    output logic                        buf_start,
    output logic                        buf_take,
    output fetch_rsp_t                  fetch_rsp,
    output logic                        mem_request,
    output logic [31:0]                 mem_addr
);

    localparam int WAY_BITS = $clog2(NUM_WAYS);

    localparam logic [2:0] S_IDLE    = 3'd0;
    localparam logic [2:0] S_LOOKUP  = 3'd1;
    localparam logic [2:0] S_READ    = 3'd2;
    localparam logic [2:0] S_REFILL  = 3'd3;
    localparam logic [2:0] S_RESPOND = 3'd4;

    logic [2:0]          state;
    logic                from_miss;
    fetch_addr_u         req_addr;
    fetch_addr_u         block_addr;
    logic [WAY_BITS-1:0] victim_q;

    always_ff @(posedge Clk) begin
        if (!rst_n) begin
            state     <= S_IDLE;
            from_miss <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (fetch_req.enable) begin
                        state <= S_LOOKUP;
                    end
                end
                S_LOOKUP: state <= S_READ;
                S_READ: begin
                    from_miss <= !hit;
                    state     <= hit ? S_RESPOND : S_REFILL;
                end
                S_REFILL: begin
                    if (last_word) begin
                        state <= S_RESPOND;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Request address and victim are held for the whole miss
    always_ff @(posedge Clk) begin
        if (state == S_IDLE && fetch_req.enable) begin
            req_addr <= fetch_req.addr;
        end
        if (state == S_READ && !hit) begin
            victim_q <= victim_way;
        end
    end

    always_comb begin
        block_addr = req_addr;
        block_addr.f.word = '0;
        block_addr.f.byte_off = '0;
    end

    assign lookup_en = (state == S_LOOKUP);
    assign rd_en     = (state == S_READ) && hit;
    assign rd_way    = hit_way;

    // Buffer counter restarts as the refill begins
    assign buf_start = (state == S_READ) && !hit;
    assign buf_take  = (state == S_REFILL) && mem_data_ready;
    assign fill_en   = (state == S_REFILL) && last_word;
    assign fill_way  = victim_q;

    assign mem_request = (state == S_REFILL);
    assign mem_addr    = block_addr.raw;

    assign fetch_rsp.ready       = (state == S_RESPOND);
    assign fetch_rsp.busy        = (state != S_IDLE);
    assign fetch_rsp.instruction = from_miss ? crit_word : rd_data;

endmodule

/* verilog/icache_tag_array.sv */
`timescale 1ns/10ps

module icache_tag_array
    import icache_geom_pkg::*;
#(
    parameter int NUM_WAYS = 4
) (
    input  logic                        Clk,
    input  logic                        rst_n,
    input  logic                        lookup_en,
    input  fetch_addr_u                 lookup_addr,
    input  logic                        fill_en,
    input  logic [$clog2(NUM_WAYS)-1:0] fill_way,
    input  fetch_addr_u                 fill_addr,
    output logic                        hit,
    output logic [$clog2(NUM_WAYS)-1:0] hit_way,
    output logic [$clog2(NUM_WAYS)-1:0] victim_way
);

    localparam int WAY_BITS = $clog2(NUM_WAYS);

    tag_t                               tags [NUM_SETS][NUM_WAYS];
    logic [NUM_SETS-1:0][NUM_WAYS-1:0]  valid;
    logic [NUM_SETS-1:0][WAY_BITS-1:0]  rr_ptr;

    logic                hit_c;
    logic [WAY_BITS-1:0] hit_way_c;
    logic [WAY_BITS-1:0] victim_c;
    logic                free_found;
    set_idx_t            lk_set;
    set_idx_t            fl_set;

    assign lk_set = lookup_addr.f.set;
    assign fl_set = fill_addr.f.set;

    // Compare all ways of the set at once
    always_comb begin
        hit_c      = 1'b0;
        hit_way_c  = '0;
        victim_c   = rr_ptr[lk_set];
        free_found = 1'b0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (valid[lk_set][w] && tags[lk_set][w] == lookup_addr.f.tag) begin
                hit_c     = 1'b1;
                hit_way_c = WAY_BITS'(w);
            end
            if (!free_found && !valid[lk_set][w]) begin
                victim_c   = WAY_BITS'(w);
                free_found = 1'b1;
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (!rst_n) begin
            hit    <= 1'b0;
            valid  <= '0;
            rr_ptr <= '0;
        end else begin
            if (lookup_en) begin
                hit <= hit_c;
            end
            if (fill_en) begin
                valid[fl_set][fill_way] <= 1'b1;
                // Pointer only moves when a valid way was replaced
                if (&valid[fl_set]) begin
                    if (rr_ptr[fl_set] == WAY_BITS'(NUM_WAYS - 1)) begin
                        rr_ptr[fl_set] <= '0;
                    end else begin
                        rr_ptr[fl_set] <= rr_ptr[fl_set] + 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (lookup_en) begin
            hit_way    <= hit_way_c;
            victim_way <= victim_c;
        end
        if (fill_en) begin
            tags[fl_set][fill_way] <= fill_addr.f.tag;
        end
    end

endmodule

/* verilog/icache_data_array.sv */
`timescale 1ns/10ps

module icache_data_array
    import icache_geom_pkg::*;
#(
    parameter int NUM_WAYS = 4
) (
    input  logic                        Clk,
    input  logic                        rd_en,
    input  logic [$clog2(NUM_WAYS)-1:0] rd_way,
    input  fetch_addr_u                 rd_addr,
    input  logic                        fill_en,
    input  logic [$clog2(NUM_WAYS)-1:0] fill_way,
    input  set_idx_t                    fill_set,
    input  word_t [BLOCK_WORDS-1:0]     block_data,
    output word_t                       rd_data
);

    // One whole block per set and way
    word_t [BLOCK_WORDS-1:0] blocks [NUM_SETS][NUM_WAYS];

    always_ff @(posedge Clk) begin
        if (fill_en) begin
            blocks[fill_set][fill_way] <= block_data;
        end
    end

    // Single word out, one cycle after rd_en
    always_ff @(posedge Clk) begin
        if (rd_en) begin
            rd_data <= blocks[rd_addr.f.set][rd_way][rd_addr.f.word];
        end
    end

endmodule

/* verilog/icache_refill_buffer.sv */
`timescale 1ns/10ps

module icache_refill_buffer
    import icache_geom_pkg::*;
(
    input  logic                    Clk,
    input  logic                    rst_n,
    input  logic                    buf_start,
    input  logic                    buf_take,
    input  word_idx_t               crit_idx,
    input  word_t                   mem_data,
    output word_t [BLOCK_WORDS-1:0] block_data,
    output word_t                   crit_word,
    output logic                    last_word
);

    word_idx_t               count;
    word_t [BLOCK_WORDS-1:0] words_q;
    word_t                   crit_q;

    always_ff @(posedge Clk) begin
        if (!rst_n) begin
            count <= '0;
        end else if (buf_start) begin
            count <= '0;
        end else if (buf_take) begin
            count <= count + 1'b1;
        end
    end

    always_ff @(posedge Clk) begin
        if (buf_take) begin
            words_q[count] <= mem_data;
            if (count == crit_idx) begin
                crit_q <= mem_data;
            end
        end
    end

    assign last_word = buf_take && (count == WORD_BITS'(BLOCK_WORDS - 1));
    assign crit_word = crit_q;

    // Last word goes straight through so the block is written on its edge
    always_comb begin
        block_data = words_q;
        if (buf_take) begin
            block_data[count] = mem_data;
        end
    end

endmodule

/* verilog/icache_top.sv */
`timescale 1ns/10ps

module icache_top
    import icache_geom_pkg::*;
    import icache_port_pkg::*;
#(
    parameter int NUM_WAYS = 4
) (
    input  logic       Clk,
    input  logic       rst_n,
    input  fetch_req_t fetch_req,
    output fetch_rsp_t fetch_rsp,
    output mem_req_t   mem_req,
    input  mem_rsp_t   mem_rsp
);

    localparam int WAY_BITS = $clog2(NUM_WAYS);

    logic                    lookup_en;
    logic                    hit;
    logic [WAY_BITS-1:0]     hit_way;
    logic [WAY_BITS-1:0]     victim_way;
    logic                    rd_en;
    logic [WAY_BITS-1:0]     rd_way;
    word_t                   rd_data;
    logic                    fill_en;
    logic [WAY_BITS-1:0]     fill_way;
    logic                    buf_start;
    logic                    buf_take;
    word_t [BLOCK_WORDS-1:0] block_data;
    word_t                   crit_word;
    logic                    last_word;

    // Core holds its address until ready, so the datapath reads it directly
    icache_ctrl #(.NUM_WAYS(NUM_WAYS)) u_ctrl (
        .Clk            (Clk),
        .rst_n          (rst_n),
        .fetch_req      (fetch_req),
        .hit            (hit),
        .hit_way        (hit_way),
        .victim_way     (victim_way),
        .rd_data        (rd_data),
        .crit_word      (crit_word),
        .last_word      (last_word),
        .mem_data_ready (mem_rsp.data_ready),
        .lookup_en      (lookup_en),
        .rd_en          (rd_en),
        .rd_way         (rd_way),
        .fill_en        (fill_en),
        .fill_way       (fill_way),
        .buf_start      (buf_start),
        .buf_take       (buf_take),
        .fetch_rsp      (fetch_rsp),
        .mem_request    (mem_req.request),
        .mem_addr       (mem_req.addr)
    );

    icache_tag_array #(.NUM_WAYS(NUM_WAYS)) u_tags (
        .Clk         (Clk),
        .rst_n       (rst_n),
        .lookup_en   (lookup_en),
        .lookup_addr (fetch_req.addr),
        .fill_en     (fill_en),
        .fill_way    (fill_way),
        .fill_addr   (fetch_req.addr),
        .hit         (hit),
        .hit_way     (hit_way),
        .victim_way  (victim_way)
    );

    icache_data_array #(.NUM_WAYS(NUM_WAYS)) u_data (
        .Clk        (Clk),
        .rd_en      (rd_en),
        .rd_way     (rd_way),
        .rd_addr    (fetch_req.addr),
        .fill_en    (fill_en),
        .fill_way   (fill_way),
        .fill_set   (fetch_req.addr.f.set),
        .block_data (block_data),
        .rd_data    (rd_data)
    );

    icache_refill_buffer u_refill (
        .Clk        (Clk),
        .rst_n      (rst_n),
        .buf_start  (buf_start),
        .buf_take   (buf_take),
        .crit_idx   (fetch_req.addr.f.word),
        .mem_data   (mem_rsp.data),
        .block_data (block_data),
        .crit_word  (crit_word),
        .last_word  (last_word)
    );

endmodule

/* tests/sdram_model.sv */
`timescale 1ns/10ps

module sdram_model
    import icache_geom_pkg::*;
    import icache_port_pkg::*;
(
    input  logic     Clk,
    input  logic     rst_n,
    input  mem_req_t mem_req,
    output mem_rsp_t mem_rsp
);

    localparam logic [31:0] DATA_KEY = 32'hA5A5_0000;

    int unsigned gap;
    logic [31:0] base;

    // Words of a block come back in order, each after a random gap
    initial begin
        mem_rsp = '0;
        forever begin
            @(negedge Clk);
            if (rst_n && mem_req.request) begin
                base = mem_req.addr;
                for (int i = 0; i < BLOCK_WORDS; i++) begin
                    gap = $urandom_range(3, 0);
                    repeat (gap) @(negedge Clk);
                    mem_rsp.data       = (base + 32'(4 * i)) ^ DATA_KEY;
                    mem_rsp.data_ready = 1'b1;
                    @(negedge Clk);
                    mem_rsp.data_ready = 1'b0;
                end
            end
        end
    end

endmodule

/* tests/icache_tb.sv */
`timescale 1ns/10ps

module icache_tb
    import icache_geom_pkg::*;
    import icache_port_pkg::*;
();

    localparam int NUM_WAYS        = 4;
    localparam int TABLE_ROWS      = 20;
    localparam int NUM_RANDOM      = 60;
    localparam int WATCHDOG_CYCLES = (TABLE_ROWS + NUM_RANDOM) * 40 + 500;
    localparam int FETCH_LIMIT     = 60;
    localparam int OFFSET_BITS     = BYTE_BITS + WORD_BITS;
    localparam logic [31:0] DATA_KEY   = 32'hA5A5_0000;
    localparam logic [31:0] BLOCK_MASK = ~32'(BLOCK_WORDS * 4 - 1);

    typedef struct packed {
        logic [31:0] addr;
        logic        exp_hit;
        logic        reset_first;
    } stim_row_t;

    // Set 0 sees tags A to F at 0x1000 + n*0x80, set 1 one block at 0x1010
    localparam stim_row_t ROWS [TABLE_ROWS] = '{
        '{32'h0000_1000, 1'b0, 1'b1},
        '{32'h0000_1000, 1'b1, 1'b0},
        '{32'h0000_1004, 1'b1, 1'b0},
        '{32'h0000_1008, 1'b1, 1'b0},
        '{32'h0000_100C, 1'b1, 1'b0},
        '{32'h0000_1080, 1'b0, 1'b0},
        '{32'h0000_1100, 1'b0, 1'b0},
        '{32'h0000_1180, 1'b0, 1'b0},
        '{32'h0000_1200, 1'b0, 1'b0},
        '{32'h0000_1084, 1'b1, 1'b0},
        '{32'h0000_1280, 1'b0, 1'b0},
        '{32'h0000_1000, 1'b0, 1'b0},
        '{32'h0000_1088, 1'b0, 1'b0},
        '{32'h0000_1204, 1'b1, 1'b0},
        '{32'h0000_1284, 1'b1, 1'b0},
        '{32'h0000_100C, 1'b1, 1'b0},
        '{32'h0000_1010, 1'b0, 1'b0},
        '{32'h0000_1014, 1'b1, 1'b0},
        '{32'h0000_1000, 1'b0, 1'b1},
        '{32'h0000_1000, 1'b1, 1'b0}
    };

    logic       Clk = 1'b0;
    logic       rst_n;
    fetch_req_t fetch_req;
    fetch_rsp_t fetch_rsp;
    mem_req_t   mem_req;
    mem_rsp_t   mem_rsp;

    // Reference cache state
    tag_t ref_tag   [NUM_SETS][NUM_WAYS];
    logic ref_valid [NUM_SETS][NUM_WAYS];
    int   ref_ptr   [NUM_SETS];

    int error_count = 0;
    int test_pass   = 0;
    int test_fail   = 0;

    always #5 Clk = ~Clk;

    icache_top #(.NUM_WAYS(NUM_WAYS)) dut0 (
        .Clk       (Clk),
        .rst_n     (rst_n),
        .fetch_req (fetch_req),
        .fetch_rsp (fetch_rsp),
        .mem_req   (mem_req),
        .mem_rsp   (mem_rsp)
    );

    sdram_model mem0 (
        .Clk     (Clk),
        .rst_n   (rst_n),
        .mem_req (mem_req),
        .mem_rsp (mem_rsp)
    );

    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string what);
        if (actual !== expected) begin
            error_count++;
            $display("Fail at %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic clear_reference();
        for (int s = 0; s < NUM_SETS; s++) begin
            ref_ptr[s] = 0;
            for (int w = 0; w < NUM_WAYS; w++) begin
                ref_valid[s][w] = 1'b0;
            end
        end
    endtask

    // First invalid way, else the set's round-robin pointer
    task automatic predict_access(input logic [31:0] addr, output logic hit);
        int   s;
        int   way;
        tag_t tag;
        s   = int'((addr >> OFFSET_BITS) % NUM_SETS);
        tag = TAG_BITS'(addr >> (OFFSET_BITS + SET_BITS));
        hit = 1'b0;
        way = -1;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (ref_valid[s][w] && ref_tag[s][w] == tag) begin
                hit = 1'b1;
            end
        end
        if (!hit) begin
            for (int w = NUM_WAYS - 1; w >= 0; w--) begin
                if (!ref_valid[s][w]) begin
                    way = w;
                end
            end
            if (way < 0) begin
                way        = ref_ptr[s];
                ref_ptr[s] = (ref_ptr[s] + 1) % NUM_WAYS;
            end
            ref_tag[s][way]   = tag;
            ref_valid[s][way] = 1'b1;
        end
    endtask

    task automatic apply_reset();
        fetch_req.enable = 1'b0;
        rst_n = 1'b0;
        repeat (8) @(negedge Clk);
        rst_n = 1'b1;
        clear_reference();
    endtask

    // Reset lands while the fetch is still in its lookup
    task automatic leave_fetch_pending(input logic [31:0] addr);
        fetch_req.enable   = 1'b1;
        fetch_req.addr.raw = addr;
        @(negedge Clk);
        check(32'(fetch_rsp.busy), 32'd1, "busy before reset");
    endtask

    task automatic check_idle();
        check(32'(fetch_rsp.busy), 32'd0, "busy after reset");
        check(32'(fetch_rsp.ready), 32'd0, "ready after reset");
        check(32'(mem_req.request), 32'd0, "memory request after reset");
    endtask

    task automatic run_fetch(input logic [31:0] addr, input logic exp_hit);
        int          lat;
        logic        saw_req;
        logic [31:0] exp_word;
        exp_word = {addr[31:2], 2'b00} ^ DATA_KEY;
        lat      = 0;
        saw_req  = 1'b0;
        fetch_req.enable   = 1'b1;
        fetch_req.addr.raw = addr;
        @(negedge Clk);
        while (!fetch_rsp.ready && lat < FETCH_LIMIT) begin
            if (mem_req.request && !saw_req) begin
                saw_req = 1'b1;
                check(mem_req.addr, addr & BLOCK_MASK, "memory block address");
            end
            lat++;
            @(negedge Clk);
        end
        if (!fetch_rsp.ready) begin
            error_count++;
            $display("No ready for the fetch at %h within %0d cycles", addr, FETCH_LIMIT);
        end else begin
            check(fetch_rsp.instruction, exp_word, "instruction");
            check(32'(fetch_rsp.busy), 32'd1, "busy in ready cycle");
            check(32'(!saw_req), 32'(exp_hit), "hit (no memory request)");
            if (exp_hit) begin
                check(32'(lat), 32'd2, "hit latency");
            end
        end
        // One idle cycle between fetches
        fetch_req.enable = 1'b0;
        @(negedge Clk);
        check(32'(fetch_rsp.busy), 32'd0, "busy after response");
    endtask

    task automatic report_test(input int idx, input logic [31:0] addr, input int errs_before);
        if (error_count == errs_before) begin
            test_pass++;
            $display("Fetch %0d at %h: ok", idx, addr);
        end else begin
            test_fail++;
            $display("Fetch %0d at %h: FAILED", idx, addr);
        end
    endtask

    initial begin
        logic        pred;
        logic [31:0] addr;
        int          errs;
        void'($urandom(50307));
        fetch_req = '0;
        rst_n     = 1'b0;
        clear_reference();
        for (int i = 0; i < TABLE_ROWS; i++) begin
            errs = error_count;
            if (ROWS[i].reset_first) begin
                if (rst_n) begin
                    leave_fetch_pending(ROWS[i].addr);
                end
                apply_reset();
                check_idle();
            end
            predict_access(ROWS[i].addr, pred);
            run_fetch(ROWS[i].addr, ROWS[i].exp_hit);
            report_test(i, ROWS[i].addr, errs);
        end
        // Eight tags per set in this range, so ways get evicted
        for (int i = 0; i < NUM_RANDOM; i++) begin
            errs = error_count;
            addr = 32'h0000_2000 + (32'($urandom_range(255, 0)) << 2);
            predict_access(addr, pred);
            run_fetch(addr, pred);
            report_test(TABLE_ROWS + i, addr, errs);
        end
        $display("Tests passed: %0d, failed: %0d", test_pass, test_fail);
        if (test_fail == 0 && error_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge Clk);
        $display("Run timed out after %0d cycles", WATCHDOG_CYCLES);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

/* icache_top.f */
verilog/icache_geom_pkg.sv
verilog/icache_port_pkg.sv
verilog/icache_ctrl.sv
verilog/icache_tag_array.sv
verilog/icache_data_array.sv
verilog/icache_refill_buffer.sv
verilog/icache_top.sv
tests/sdram_model.sv
tests/icache_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the instruction cache testbench with Verilator

rm -rf obj_dir sim.log

verilator --binary --timing -f icache_top.f --top-module icache_tb -o icache_sim \
    && ./obj_dir/icache_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation error"; exit 1; }

cat sim.log

# Any failure line in the log fails the run
grep -q "RESULT: FAIL" sim.log && exit 1 || exit 0
